// ==== common/pitch_pkg.sv ====
// Pitch detector shared widths, note one-hot type, pitch table, threshold, segment codes

`default_nettype none

package pitch_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    localparam int w_sample   = 24;  // Microphone sample
    localparam int w_distance = 20;  // Period in clocks, saturates at all ones
    localparam int w_note     = 12;  // Semitones per octave
    localparam int w_seg      = 8;   // abcdefgh
    localparam int w_digit    = 4;   // Digit enables on the board

    // One-hot note, MSB is C, LSB is B, zero means silence
    typedef logic [w_note - 1:0] note_t;

    localparam note_t no_note = 12'b0000_0000_0000;
    localparam note_t note_c  = 12'b1000_0000_0000;
    localparam note_t note_cs = 12'b0100_0000_0000;
    localparam note_t note_d  = 12'b0010_0000_0000;
    localparam note_t note_ds = 12'b0001_0000_0000;
    localparam note_t note_e  = 12'b0000_1000_0000;
    localparam note_t note_f  = 12'b0000_0100_0000;
    localparam note_t note_fs = 12'b0000_0010_0000;
    localparam note_t note_g  = 12'b0000_0001_0000;
    localparam note_t note_gs = 12'b0000_0000_1000;
    localparam note_t note_a  = 12'b0000_0000_0100;
    localparam note_t note_as = 12'b0000_0000_0010;
    localparam note_t note_b  = 12'b0000_0000_0001;

    // Standard pitches in 0.01 Hz, index 0 is C
    localparam int unsigned pitch_table [w_note] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    // Upward crossing of this level starts a new period
    localparam logic [w_sample - 1:0] crossing_threshold = 24'h110000;

    // ------------------------------
    // Seven-segment codes, active low
    // ------------------------------

    localparam logic [w_seg - 1:0] seg_blank = 8'b1111_1111;

    // Letters C through B, h lit on sharps
    localparam logic [w_seg - 1:0] seg_pattern [w_note] = '{
        8'b0110_0011, 8'b0110_0010, 8'b1000_0101, 8'b1000_0100,
        8'b0110_0001, 8'b0111_0001, 8'b0111_0000, 8'b0100_0011,
        8'b0100_0010, 8'b0001_0001, 8'b0001_0000, 8'b1100_0001
    };

    localparam logic [w_digit - 1:0] digit_right = 4'b1110;  // Rightmost digit only

endpackage

`default_nettype wire

// ==== verilog/mic_i2s_receiver.sv ====
// I2S master for a MEMS microphone: bit clock, word select, left-channel sample capture

`timescale 1ns/100ps
`default_nettype none

module mic_i2s_receiver
#(
    parameter int sck_half = 8  // Clocks per half bit clock
)
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            sd,
    output logic                            sck,
    output logic                            ws,
    output logic                            lr,
    output logic [pitch_pkg::w_sample - 1:0] sample
);

    import pitch_pkg::*;

    localparam int w_div = $clog2(sck_half + 1);

    // ------------------------------
    // Bit clock divider
    // ------------------------------

    logic [w_div - 1:0] div_cnt;
    logic               div_tick;
    logic               sck_rise;  // sck about to go high
    logic               sck_fall;  // sck about to go low

    assign div_tick = (div_cnt == w_div'(sck_half - 1));
    assign sck_rise = div_tick & ~sck;
    assign sck_fall = div_tick &  sck;

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (div_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;

    // ------------------------------
    // Frame position, 64 bit clocks
    // ------------------------------

    logic [5:0] bit_cnt;  // sck period within frame

    // Advances on falling sck, wraps 63 -> 0 as ws falls
    always_ff @(posedge clk or posedge reset)
        if (reset)
            bit_cnt <= 6'd0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 6'd1;

    assign ws = bit_cnt[5];  // Low for left half
    assign lr = 1'b0;        // Mic strapped to left channel

    // ------------------------------
    // Data capture
    // ------------------------------

    logic [w_sample - 1:0] shift;
    logic                  data_bit;  // Period 1..24 carries left data
    logic                  last_bit;  // LSB captured on previous clock

    assign data_bit = (bit_cnt >= 6'd1) && (bit_cnt <= 6'd24);

    always_ff @(posedge clk)
        if (sck_rise && data_bit)
            shift <= {shift[w_sample - 2:0], sd};  // MSB first

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            last_bit <= 1'b0;
            sample   <= '0;
        end
        else
        begin
            last_bit <= sck_rise && (bit_cnt == 6'd24);
            if (last_bit)
                sample <= shift;  // Held until next frame
        end

endmodule

`default_nettype wire

// ==== pitch/period_meter.sv ====
// Period meter: clock count between rising threshold crossings of the sample

`timescale 1ns/100ps
`default_nettype none

module period_meter
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [pitch_pkg::w_sample - 1:0]   sample,
    output logic [pitch_pkg::w_distance - 1:0] distance
);

    import pitch_pkg::*;

    localparam logic [w_distance - 1:0] count_max = '1;

    logic [w_sample - 1:0]   prev_sample;  // Sample one clock back
    logic [w_distance - 1:0] counter;      // Clocks since last crossing
    logic                    crossing;

    // Previous below, current at or above
    assign crossing = (sample >= crossing_threshold)
                    && (prev_sample < crossing_threshold);

    // ------------------------------
    // Edge history
    // ------------------------------

    always_ff @(posedge clk or posedge reset)
        if (reset)
            prev_sample <= '0;
        else
            prev_sample <= sample;

    // ------------------------------
    // Counter and latch
    // ------------------------------

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            counter  <= '0;
            distance <= '0;
        end
        else if (crossing)
        begin
            distance <= counter;  // Full period just ended
            counter  <= '0;
        end
        else if (counter != count_max)
            counter <= counter + 1'b1;  // Stick at all ones, no wrap

endmodule

`default_nettype wire

// ==== pitch/note_classifier.sv ====
// Note classifier: period windows per semitone over three octaves, registered one-hot note

`timescale 1ns/100ps
`default_nettype none

module note_classifier
#(
    parameter int unsigned clk_hz = 50000000
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic [pitch_pkg::w_distance - 1:0] distance,
    output pitch_pkg::note_t                   raw_note
);

    import pitch_pkg::*;

    localparam longint unsigned max_distance = (64'd1 << w_distance) - 64'd1;

    // ------------------------------
    // Window bounds, elaboration only
    // ------------------------------

    // Period in clocks scaled by percent, octave 0..2 below the table pitch
    function automatic longint unsigned window_bound
    (
        input int idx,
        input int octave,
        input int percent
    );
        longint unsigned num;
        longint unsigned bound;
        num   = clk_hz;
        num   = num * percent * (64'd1 << octave);  // clk * 100 / f100 * pct / 100
        bound = num / pitch_table[idx];
        if (bound > max_distance)
            bound = max_distance;  // Clamp to counter range
        return bound;
    endfunction

    // ------------------------------
    // Window compare
    // ------------------------------

    note_t note_hits;

    for (genvar n = 0; n < w_note; n++)
    begin : g_note
        logic [2:0] hit;  // One per octave

        for (genvar k = 0; k < 3; k++)
        begin : g_octave
            localparam logic [w_distance - 1:0] lo = w_distance'(window_bound(n, k, 96));
            localparam logic [w_distance - 1:0] hi = w_distance'(window_bound(n, k, 104));

            // Strictly inside, both ends open
            assign hit[k] = (distance > lo) && (distance < hi);
        end

        // Table index 0 is C, which sits at the MSB
        assign note_hits[w_note - 1 - n] = |hit;
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge clk or posedge reset)
        if (reset)
            raw_note <= no_note;
        else
            raw_note <= note_hits;  // One clock behind distance

endmodule

`default_nettype wire

// ==== pitch/note_stabilizer.sv ====
// Note stabilizer: passes a note on after it holds for 2**stable_bits clocks

`timescale 1ns/100ps
`default_nettype none

module note_stabilizer
#(
    parameter int stable_bits = 18
)
(
    input  logic             clk,
    input  logic             reset,
    input  pitch_pkg::note_t raw_note,
    output pitch_pkg::note_t stable_note
);

    import pitch_pkg::*;

    note_t                    d_note;  // raw_note one clock back
    logic [stable_bits - 1:0] hold_cnt;  // Clocks of agreement

    always_ff @(posedge clk or posedge reset)
        if (reset)
            d_note <= no_note;
        else
            d_note <= raw_note;

    // Any change restarts the hold time
    always_ff @(posedge clk or posedge reset)
        if (reset)
            hold_cnt <= '0;
        else if (raw_note != d_note)
            hold_cnt <= '0;
        else
            hold_cnt <= hold_cnt + 1'b1;

    // Short glitches never get here
    always_ff @(posedge clk or posedge reset)
        if (reset)
            stable_note <= no_note;
        else if (&hold_cnt)
            stable_note <= d_note;

endmodule

`default_nettype wire

// ==== verilog/note_segment_display.sv ====
// Seven-segment letter decode for the stable note, plus digit enable

`timescale 1ns/100ps
`default_nettype none

module note_segment_display
(
    input  logic                           clk,
    input  logic                           reset,
    input  pitch_pkg::note_t                stable_note,
    output logic [pitch_pkg::w_seg - 1:0]   abcdefgh,
    output logic [pitch_pkg::w_digit - 1:0] digit
);

    import pitch_pkg::*;

    // Registered lookup, one clock behind stable_note
    always_ff @(posedge clk or posedge reset)
        if (reset)
            abcdefgh <= seg_blank;
        else
            case (stable_note)
                note_c:  abcdefgh <= seg_pattern[0];
                note_cs: abcdefgh <= seg_pattern[1];   // C.
                note_d:  abcdefgh <= seg_pattern[2];
                note_ds: abcdefgh <= seg_pattern[3];   // d.
                note_e:  abcdefgh <= seg_pattern[4];
                note_f:  abcdefgh <= seg_pattern[5];
                note_fs: abcdefgh <= seg_pattern[6];   // F.
                note_g:  abcdefgh <= seg_pattern[7];
                note_gs: abcdefgh <= seg_pattern[8];   // G.
                note_a:  abcdefgh <= seg_pattern[9];
                note_as: abcdefgh <= seg_pattern[10];  // A.
                note_b:  abcdefgh <= seg_pattern[11];
                default: abcdefgh <= seg_blank;        // Silence or multi-hot
            endcase

    // Single digit in use
    assign digit = digit_right;

endmodule

`default_nettype wire

// ==== verilog/pitch_detector_top.sv ====
// Pitch detector top: I2S receiver, period meter, classifier, stabilizer, segment display

`timescale 1ns/100ps
`default_nettype none

module pitch_detector_top
#(
    parameter int unsigned clk_hz      = 50000000,
    parameter int          sck_half    = 8,
    parameter int          stable_bits = 18
)
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           sd,
    output logic                           sck,
    output logic                           ws,
    output logic                           lr,
    output logic [pitch_pkg::w_seg - 1:0]   abcdefgh,
    output logic [pitch_pkg::w_digit - 1:0] digit,
    output pitch_pkg::note_t                stable_note  // Status
);

    import pitch_pkg::*;

    logic [w_sample - 1:0]   sample;
    logic [w_distance - 1:0] distance;
    note_t                   raw_note;

    // ------------------------------
    // Pipeline
    // ------------------------------

    mic_i2s_receiver #(.sck_half(sck_half)) receiver_i
    (
        .clk    (clk),
        .reset  (reset),
        .sd     (sd),
        .sck    (sck),
        .ws     (ws),
        .lr     (lr),
        .sample (sample)
    );

    period_meter meter_i
    (
        .clk      (clk),
        .reset    (reset),
        .sample   (sample),
        .distance (distance)
    );

    note_classifier #(.clk_hz(clk_hz)) classifier_i
    (
        .clk      (clk),
        .reset    (reset),
        .distance (distance),
        .raw_note (raw_note)
    );

    note_stabilizer #(.stable_bits(stable_bits)) stabilizer_i
    (
        .clk         (clk),
        .reset       (reset),
        .raw_note    (raw_note),
        .stable_note (stable_note)
    );

    note_segment_display display_i
    (
        .clk         (clk),
        .reset       (reset),
        .stable_note (stable_note),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

endmodule

`default_nettype wire

// ==== verification/pitch_detector_tb.sv ====
// Testbench with clock, reset, I2S microphone model, golden tone list, checks and timeout

`timescale 1ns/100ps
`default_nettype none

module pitch_detector_tb;

    localparam logic [23:0] crossing_level = 24'h110000;  // Upward crossing starts a period
    localparam logic [23:0] noise_guard    = 24'h010000;  // Quiet band just below threshold
    localparam logic [7:0]  blank_pattern  = 8'hff;
    localparam logic [3:0]  right_digit    = 4'b1110;
    localparam int          frame_clocks   = 256;         // 64 bit clocks of 4 clocks each

    logic        clk   = 1'b0;
    logic        reset = 1'b1;
    logic        sd    = 1'b0;
    logic        sck;
    logic        ws;
    logic        lr;
    logic [7:0]  abcdefgh;
    logic [3:0]  digit;
    logic [11:0] stable_note;

    // Golden tone list
    int          period_q [$];
    int          count_q  [$];
    logic [11:0] note_q   [$];
    logic [7:0]  seg_q    [$];

    // Tone handed to the microphone model
    int   tone_period = 1;
    int   tone_phase  = 0;
    int   tone_left   = 0;     // Samples still to send
    logic tone_done   = 1'b0;  // Last sample's frame is over

    int   seed         = 32'h8c2d;
    int   value_errors = 0;
    int   other_errors = 0;
    int   cycle_count  = 0;
    int   cycle_limit  = 0;
    logic limit_ready  = 1'b0;

    pitch_detector_top
    #(
        .clk_hz      (5120000),
        .sck_half    (2),
        .stable_bits (10)
    )
    dut_i
    (
        .clk         (clk),
        .reset       (reset),
        .sd          (sd),
        .sck         (sck),
        .ws          (ws),
        .lr          (lr),
        .abcdefgh    (abcdefgh),
        .digit       (digit),
        .stable_note (stable_note)
    );

    initial
    begin
        forever #20 clk = ~clk;  // 40 ns
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic compare_value
    (
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual == expected)
        else
        begin
            value_errors++;
            $display("** Error %s: expected %0h, got %0h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

    // Triangle 0 .. 24'h200000 over one period
    function automatic logic [23:0] triangle_level(input int period, input int phase);
        longint unsigned span;
        longint unsigned level;
        if (2 * phase < period)
            span = 64'(phase);           // Rising half
        else
            span = 64'(period - phase);  // Falling half
        level = (span * 64'h40_0000) / 64'(period);
        return level[23:0];
    endfunction

    task automatic read_golden();
        int          fd;
        int          rc;
        int          p;
        int          c;
        logic [11:0] n;
        logic [7:0]  s;
        string       line;
        fd = $fopen("verification/pitch_golden.txt", "r");
        assert (fd != 0)
        else
        begin
            $display("Could not open the golden file verification/pitch_golden.txt");
            other_errors++;
        end
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc != 0 && $sscanf(line, "%d %d %h %h", p, c, n, s) == 4)  // Skips comments
                begin
                    assert (p > 0 && c > 0)
                    else
                    begin
                        $display("Golden file line has a zero period or count: %s", line);
                        other_errors++;
                    end
                    if (p > 0 && c > 0)
                    begin
                        period_q.push_back(p);
                        count_q.push_back(c);
                        note_q.push_back(n);
                        seg_q.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // Microphone model
    // ------------------------------

    int          mic_bit  = 0;    // sck periods since ws fell
    logic [23:0] mic_word = '0;
    logic        prev_sck = 1'b0;
    logic        prev_ws  = 1'b0;
    logic [31:0] rnd;
    logic [23:0] level;

    always @(negedge clk)
    begin
        if (prev_sck && !sck)
        begin
            if (prev_ws && !ws)
            begin
                mic_bit = 0;  // New frame
                if (tone_left > 0)
                begin
                    level = triangle_level(tone_period, tone_phase);
                    rnd   = $random(seed);
                    // Noise keeps each sample on its side of the threshold
                    if (level >= crossing_level || level < crossing_level - noise_guard)
                        level = level + {8'h00, rnd[15:0]};
                    mic_word   = level;
                    tone_phase = (tone_phase + 1 == tone_period) ? 0 : tone_phase + 1;
                    tone_left  = tone_left - 1;
                end
                else
                begin
                    mic_word  = '0;    // Silence
                    tone_done = 1'b1;
                end
            end
            else
                mic_bit = mic_bit + 1;
        end
        prev_sck = sck;
        prev_ws  = ws;
        if (mic_bit >= 1 && mic_bit <= 24)
            sd <= mic_word[24 - mic_bit];  // MSB first
        else
            sd <= 1'b0;
    end

    // ------------------------------
    // Bus monitor
    // ------------------------------

    int   mon_cycle     = 0;
    int   last_sck_rise = -1;
    int   last_ws_rise  = -1;
    logic mon_sck       = 1'b0;
    logic mon_ws        = 1'b0;

    always @(negedge clk)
        if (!reset)
        begin
            mon_cycle++;
            compare_value("digit", 32'(right_digit), 32'(digit));
            compare_value("lr", 0, 32'(lr));
            if (sck && !mon_sck)
            begin
                if (last_sck_rise >= 0)
                    compare_value("sck period", 4, mon_cycle - last_sck_rise);
                last_sck_rise = mon_cycle;
            end
            if (ws && !mon_ws)
            begin
                if (last_ws_rise >= 0)
                    compare_value("ws period", frame_clocks, mon_cycle - last_ws_rise);
                last_ws_rise = mon_cycle;
            end
            mon_sck = sck;
            mon_ws  = ws;
        end

    // ------------------------------
    // Timeout
    // ------------------------------

    initial
    begin
        wait (limit_ready);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tone list did not finish within %0d clock cycles", cycle_limit);
        other_errors++;
        report_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial
    begin
        int   limit;
        int   tone_clocks;
        logic done_seen;

        read_golden();
        assert (period_q.size() > 0)
        else
        begin
            $display("The golden file holds no tones to play");
            other_errors++;
        end

        limit = 32 * frame_clocks;  // Reset, idle and margin
        foreach (period_q[i])
            limit += (period_q[i] * count_q[i] + 2) * frame_clocks;
        cycle_limit = limit;
        limit_ready = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Display stays dark over idle frames
        repeat (4 * frame_clocks)
        begin
            @(negedge clk);
            compare_value("abcdefgh", 32'(blank_pattern), 32'(abcdefgh));
            compare_value("stable_note", 0, 32'(stable_note));
        end

        foreach (period_q[t])
        begin
            @(posedge clk);
            tone_period = period_q[t];
            tone_phase  = 0;
            tone_left   = period_q[t] * count_q[t];
            tone_done   = 1'b0;
            tone_clocks = 0;
            done_seen   = 1'b0;
            while (!done_seen)
            begin
                @(negedge clk);
                tone_clocks++;
                // Still dark during the first period of the first tone
                if (t == 0 && tone_clocks < period_q[t] * frame_clocks)
                begin
                    compare_value("abcdefgh", 32'(blank_pattern), 32'(abcdefgh));
                    compare_value("stable_note", 0, 32'(stable_note));
                end
                @(posedge clk);
                done_seen = tone_done;
            end
            @(negedge clk);
            compare_value($sformatf("stable_note (tone %0d)", t), 32'(note_q[t]),
                          32'(stable_note));
            compare_value($sformatf("abcdefgh (tone %0d)", t), 32'(seg_q[t]), 32'(abcdefgh));
        end

        report_counts();
        if (value_errors == 0 && other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/pitch_golden.txt ====
# period_samples periods note_onehot_hex abcdefgh_hex
# Period in 20 kHz samples, note MSB is C and LSB is B, segments active low
45  4  004  11
90  3  004  11
180 3  004  11
43  4  002  10
76  4  800  63
61  4  080  61
54  4  020  70
68  4  200  85
48  4  008  42
40  4  001  c1
3   1  001  c1
20  6  000  ff
45  4  004  11

// ==== vlog.f ====
common/pitch_pkg.sv
verilog/mic_i2s_receiver.sv
pitch/period_meter.sv
pitch/note_classifier.sv
pitch/note_stabilizer.sv
verilog/note_segment_display.sv
verilog/pitch_detector_top.sv
verification/pitch_detector_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the pitch detector testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

top=pitch_detector_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -Mdir "$build_dir" -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
    echo "Simulation reported failures, see $log"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$log"; then
    echo "Simulation ended without a result line, see $log"
    exit 1
fi

echo "Simulation passed"
exit 0
